/* cpu.sv */
`timescale 1ns/1ps

module cpu
    import rv32i_types::*;
    import pipeline_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    output logic       imem_read,
    output rv32i_word  imem_address,
    input  logic       imem_resp,
    input  rv32i_word  imem_rdata,
    output logic       dmem_read,
    output logic       dmem_write,
    output logic [3:0] dmem_wmask,
    output rv32i_word  dmem_address,
    output rv32i_word  dmem_wdata,
    input  logic       dmem_resp,
    input  rv32i_word  dmem_rdata
);

    // control groups per stage
    ctrlex_reg_t  ctrlex_id, ctrlex_ex;
    ctrlmem_reg_t ctrlmem_id, ctrlmem_ex, ctrlmem_mem;
    ctrlwb_reg_t  ctrlwb_id, ctrlwb_ex, ctrlwb_mem, ctrlwb_wb;

    // decode fields
    rv32i_opcode opcode;
    funct3_t     funct3;
    funct7_t     funct7;
    reg_idx      rs1, rs2, rd;

    stage_ctrl_t stage_ctrl;
    logic        branch_taken;
    dep_t        id_rs1, id_rs2;

    // unused sources arrive as x0 from decode
    assign id_rs1 = '{idx: ctrlwb_id.rs1, used: ctrlwb_id.valid};
    assign id_rs2 = '{idx: ctrlwb_id.rs2, used: ctrlwb_id.valid};

    ctrl_word ctrl_word_i (
        .opcode  (opcode),
        .funct3  (funct3),
        .funct7  (funct7),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .ctrlex  (ctrlex_id),
        .ctrlmem (ctrlmem_id),
        .ctrlwb  (ctrlwb_id)
    );

    ctrl_pipe ctrl_pipe_i (
        .clk         (clk),
        .reset       (reset),
        .stage_ctrl  (stage_ctrl),
        .ctrlex_id   (ctrlex_id),
        .ctrlmem_id  (ctrlmem_id),
        .ctrlwb_id   (ctrlwb_id),
        .ctrlex_ex   (ctrlex_ex),
        .ctrlmem_ex  (ctrlmem_ex),
        .ctrlmem_mem (ctrlmem_mem),
        .ctrlwb_ex   (ctrlwb_ex),
        .ctrlwb_mem  (ctrlwb_mem),
        .ctrlwb_wb   (ctrlwb_wb)
    );

    datapath datapath_i (
        .clk          (clk),
        .reset        (reset),
        .imem_resp    (imem_resp),
        .imem_rdata   (imem_rdata),
        .dmem_resp    (dmem_resp),
        .dmem_rdata   (dmem_rdata),
        .stage_ctrl   (stage_ctrl),
        .ctrlex       (ctrlex_ex),
        .ctrlmem      (ctrlmem_mem),
        .ctrlwb       (ctrlwb_wb),
        .imem_read    (imem_read),
        .imem_address (imem_address),
        .dmem_read    (dmem_read),
        .dmem_write   (dmem_write),
        .dmem_wmask   (dmem_wmask),
        .dmem_address (dmem_address),
        .dmem_wdata   (dmem_wdata),
        .opcode       (opcode),
        .funct3       (funct3),
        .funct7       (funct7),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd           (rd),
        .branch_taken (branch_taken)
    );

    hazard_unit hazard_unit_i (
        .id_rs1       (id_rs1),
        .id_rs2       (id_rs2),
        .ctrlwb_ex    (ctrlwb_ex),
        .ctrlwb_mem   (ctrlwb_mem),
        .ctrlwb_wb    (ctrlwb_wb),
        .ctrlmem_mem  (ctrlmem_mem),
        .branch_taken (branch_taken),
        .imem_resp    (imem_resp),
        .dmem_resp    (dmem_resp),
        .stage_ctrl   (stage_ctrl)
    );

endmodule : cpu

/* cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// address of the first fetch after reset
`define CPU_RESET_PC 32'h0000_0000

// architectural integer registers, x0 included
`define CPU_NUM_REGS 32

`endif

/* ctrl_pipe.sv */
`timescale 1ns/1ps

module ctrl_pipe
    import pipeline_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  stage_ctrl_t  stage_ctrl,
    input  ctrlex_reg_t  ctrlex_id,
    input  ctrlmem_reg_t ctrlmem_id,
    input  ctrlwb_reg_t  ctrlwb_id,
    output ctrlex_reg_t  ctrlex_ex,
    output ctrlmem_reg_t ctrlmem_ex,
    output ctrlmem_reg_t ctrlmem_mem,
    output ctrlwb_reg_t  ctrlwb_ex,
    output ctrlwb_reg_t  ctrlwb_mem,
    output ctrlwb_reg_t  ctrlwb_wb
);

    // id/ex, flush covers both a taken branch and a decode stall
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrlex_ex  <= '0;
            ctrlmem_ex <= '0;
            ctrlwb_ex  <= '0;
        end else if (stage_ctrl.load_id_ex) begin
            if (stage_ctrl.flush_id_ex) begin
                ctrlex_ex  <= '0;
                ctrlmem_ex <= '0;
                ctrlwb_ex  <= '0;
            end else begin
                ctrlex_ex  <= ctrlex_id;
                ctrlmem_ex <= ctrlmem_id;
                ctrlwb_ex  <= ctrlwb_id;
            end
        end
    end

    // ex/mem
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrlmem_mem <= '0;
            ctrlwb_mem  <= '0;
        end else if (stage_ctrl.load_ex_mem) begin
            ctrlmem_mem <= ctrlmem_ex;
            ctrlwb_mem  <= ctrlwb_ex;
        end
    end

    // mem/wb
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrlwb_wb <= '0;
        end else if (stage_ctrl.load_mem_wb) begin
            ctrlwb_wb <= ctrlwb_mem;
        end
    end

endmodule : ctrl_pipe

/* ctrl_word.sv */
`timescale 1ns/1ps

module ctrl_word
    import rv32i_types::*;
    import pipeline_pkg::*;
(
    input  rv32i_opcode  opcode,
    input  funct3_t      funct3,
    input  funct7_t      funct7,
    input  reg_idx       rs1,
    input  reg_idx       rs2,
    input  reg_idx       rd,
    output ctrlex_reg_t  ctrlex,
    output ctrlmem_reg_t ctrlmem,
    output ctrlwb_reg_t  ctrlwb
);

    alu_op_t arith_op;
    logic    arith_ok;
    logic    reg_f7_ok;
    logic    known;

    // funct3 decode shared by op and op_imm
    always_comb begin
        arith_ok = 1'b1;
        case (funct3)
            3'b000:  arith_op = (opcode == op_reg && funct7[5]) ? alu_sub : alu_add;
            3'b010:  arith_op = alu_slt;
            3'b100:  arith_op = alu_xor;
            3'b110:  arith_op = alu_or;
            3'b111:  arith_op = alu_and;
            default: begin
                arith_op = alu_add;
                arith_ok = 1'b0;
            end
        endcase
    end

    // only sub uses the alternate funct7
    assign reg_f7_ok = (funct7 == 7'b0000000) ||
                       (funct7 == 7'b0100000 && funct3 == 3'b000);

    always_comb begin
        ctrlex     = '0;
        ctrlmem    = '0;
        ctrlwb     = '0;
        ctrlwb.rs1 = rs1;
        ctrlwb.rs2 = rs2;
        ctrlwb.rd  = rd;
        known      = 1'b1;
        case (opcode)
            op_reg: begin
                ctrlex.aluop    = arith_op;
                ctrlwb.regwrite = 1'b1;
                known           = arith_ok && reg_f7_ok;
            end
            op_imm: begin
                ctrlex.aluop    = arith_op;
                ctrlex.imm_sel  = 1'b1;
                ctrlwb.regwrite = 1'b1;
                ctrlwb.rs2      = '0;
                known           = arith_ok;
            end
            op_lui: begin
                ctrlex.imm_sel  = 1'b1;
                ctrlwb.regwrite = 1'b1;
                ctrlwb.rs1      = '0;
                ctrlwb.rs2      = '0;
            end
            op_load: begin
                ctrlex.imm_sel    = 1'b1;
                ctrlmem.dmem_read = 1'b1;
                ctrlwb.regwrite   = 1'b1;
                ctrlwb.mem_to_reg = 1'b1;
                ctrlwb.rs2        = '0;
                // lw only
                known             = (funct3 == 3'b010);
            end
            op_store: begin
                ctrlex.imm_sel     = 1'b1;
                ctrlmem.dmem_write = 1'b1;
                ctrlwb.rd          = '0;
                known              = (funct3 == 3'b010);
            end
            op_br: begin
                ctrlex.branch    = 1'b1;
                ctrlex.branch_ne = funct3[0];
                ctrlwb.rd        = '0;
                // beq and bne
                known            = (funct3[2:1] == 2'b00);
            end
            default: known = 1'b0;
        endcase

        // anything outside the subset travels as a bubble
        if (known) begin
            ctrlwb.valid = 1'b1;
        end else begin
            ctrlex  = '0;
            ctrlmem = '0;
            ctrlwb  = '0;
        end
    end

endmodule : ctrl_word

/* datapath.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module datapath
    import rv32i_types::*;
    import pipeline_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         imem_resp,
    input  rv32i_word    imem_rdata,
    input  logic         dmem_resp,
    input  rv32i_word    dmem_rdata,
    input  stage_ctrl_t  stage_ctrl,
    input  ctrlex_reg_t  ctrlex,
    input  ctrlmem_reg_t ctrlmem,
    input  ctrlwb_reg_t  ctrlwb,
    output logic         imem_read,
    output rv32i_word    imem_address,
    output logic         dmem_read,
    output logic         dmem_write,
    output logic [3:0]   dmem_wmask,
    output rv32i_word    dmem_address,
    output rv32i_word    dmem_wdata,
    output rv32i_opcode  opcode,
    output funct3_t      funct3,
    output funct7_t      funct7,
    output reg_idx       rs1,
    output reg_idx       rs2,
    output reg_idx       rd,
    output logic         branch_taken
);

    rv32i_word pc, pc_id, ir_id;
    rv32i_word redirect_pc;
    logic      fetch_en, redirect_pending;
    rv32i_word regfile [`CPU_NUM_REGS];
    rv32i_word imm_id, rs1_val, rs2_val;
    rv32i_word pc_ex, rs1_ex, rs2_ex, imm_ex;
    rv32i_word alu_b, alu_out, branch_target;
    rv32i_word alu_mem, store_mem, alu_wb, load_wb, wb_data;
    logic      rf_we;

    // fetch, a taken branch that meets a busy fetch is parked until resp
    always_ff @(posedge clk) begin
        if (reset) begin
            pc               <= `CPU_RESET_PC;
            fetch_en         <= 1'b0;
            redirect_pending <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
            if (stage_ctrl.load_pc) begin
                redirect_pending <= 1'b0;
                if (redirect_pending)
                    pc <= redirect_pc;
                else if (branch_taken)
                    pc <= branch_target;
                else
                    pc <= pc + 32'd4;
            end else if (branch_taken && stage_ctrl.load_ex_mem) begin
                redirect_pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (branch_taken && stage_ctrl.load_ex_mem && !stage_ctrl.load_pc)
            redirect_pc <= branch_target;
    end

    assign imem_read    = fetch_en;
    assign imem_address = pc;

    // if/id, an all-zero word decodes as a bubble
    always_ff @(posedge clk) begin
        if (reset) begin
            ir_id <= '0;
        end else if (stage_ctrl.load_if_id) begin
            if (stage_ctrl.flush_if_id || redirect_pending || !imem_resp)
                ir_id <= '0;
            else
                ir_id <= imem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (stage_ctrl.load_if_id)
            pc_id <= pc;
    end

    // decode fields
    assign opcode = rv32i_opcode'(ir_id[6:0]);
    assign rd     = ir_id[11:7];
    assign funct3 = ir_id[14:12];
    assign rs1    = ir_id[19:15];
    assign rs2    = ir_id[24:20];
    assign funct7 = ir_id[31:25];

    always_comb begin
        case (opcode)
            op_store: imm_id = {{20{ir_id[31]}}, ir_id[31:25], ir_id[11:7]};
            op_br:    imm_id = {{20{ir_id[31]}}, ir_id[7], ir_id[30:25], ir_id[11:8], 1'b0};
            op_lui:   imm_id = {ir_id[31:12], 12'h000};
            default:  imm_id = {{20{ir_id[31]}}, ir_id[31:20]};
        endcase
    end

    // register file, write first so wb and id can overlap
    assign rf_we   = ctrlwb.regwrite && (ctrlwb.rd != '0);
    assign wb_data = ctrlwb.mem_to_reg ? load_wb : alu_wb;

    always_ff @(posedge clk) begin
        if (rf_we)
            regfile[ctrlwb.rd] <= wb_data;
    end

    // lui adds its immediate to zero
    always_comb begin
        if (rs1 == '0 || opcode == op_lui)
            rs1_val = '0;
        else if (rf_we && ctrlwb.rd == rs1)
            rs1_val = wb_data;
        else
            rs1_val = regfile[rs1];

        if (rs2 == '0)
            rs2_val = '0;
        else if (rf_we && ctrlwb.rd == rs2)
            rs2_val = wb_data;
        else
            rs2_val = regfile[rs2];
    end

    always_ff @(posedge clk) begin
        if (stage_ctrl.load_id_ex) begin
            pc_ex  <= pc_id;
            rs1_ex <= rs1_val;
            rs2_ex <= rs2_val;
            imm_ex <= imm_id;
        end
    end

    // execute
    assign alu_b = ctrlex.imm_sel ? imm_ex : rs2_ex;

    always_comb begin
        case (ctrlex.aluop)
            alu_sub: alu_out = rs1_ex - alu_b;
            alu_and: alu_out = rs1_ex & alu_b;
            alu_or:  alu_out = rs1_ex | alu_b;
            alu_xor: alu_out = rs1_ex ^ alu_b;
            alu_slt: alu_out = {31'd0, $signed(rs1_ex) < $signed(alu_b)};
            default: alu_out = rs1_ex + alu_b;
        endcase
    end

    assign branch_target = pc_ex + imm_ex;
    assign branch_taken  = ctrlex.branch && ((rs1_ex == rs2_ex) != ctrlex.branch_ne);

    always_ff @(posedge clk) begin
        if (stage_ctrl.load_ex_mem) begin
            alu_mem   <= alu_out;
            store_mem <= rs2_ex;
        end
    end

    // memory, word accesses only
    assign dmem_read    = ctrlmem.dmem_read;
    assign dmem_write   = ctrlmem.dmem_write;
    assign dmem_wmask   = 4'b1111;
    assign dmem_address = alu_mem;
    assign dmem_wdata   = store_mem;

    always_ff @(posedge clk) begin
        if (stage_ctrl.load_mem_wb) begin
            alu_wb <= alu_mem;
            if (dmem_resp)
                load_wb <= dmem_rdata;
        end
    end

endmodule : datapath

/* hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit
    import pipeline_pkg::*;
(
    input  dep_t         id_rs1,
    input  dep_t         id_rs2,
    input  ctrlwb_reg_t  ctrlwb_ex,
    input  ctrlwb_reg_t  ctrlwb_mem,
    input  ctrlwb_reg_t  ctrlwb_wb,
    input  ctrlmem_reg_t ctrlmem_mem,
    input  logic         branch_taken,
    input  logic         imem_resp,
    input  logic         dmem_resp,
    output stage_ctrl_t  stage_ctrl
);

    logic raw_ex, raw_mem, raw_wb;
    logic id_stall, data_wait;

    // source read by decode and written by an older, still unretired stage
    function automatic logic dep_hit(dep_t src, ctrlwb_reg_t older);
        return src.used && (src.idx != '0) && older.valid && older.regwrite &&
               (older.rd == src.idx);
    endfunction

    assign raw_ex   = dep_hit(id_rs1, ctrlwb_ex)  || dep_hit(id_rs2, ctrlwb_ex);
    assign raw_mem  = dep_hit(id_rs1, ctrlwb_mem) || dep_hit(id_rs2, ctrlwb_mem);
    assign raw_wb   = dep_hit(id_rs1, ctrlwb_wb)  || dep_hit(id_rs2, ctrlwb_wb);
    assign id_stall = raw_ex || raw_mem || raw_wb;

    assign data_wait = (ctrlmem_mem.dmem_read || ctrlmem_mem.dmem_write) && !dmem_resp;

    always_comb begin
        stage_ctrl = '0;
        if (data_wait) begin
            // whole pipe frozen
            stage_ctrl = '0;
        end else if (branch_taken) begin
            // pc only moves once the current fetch is done
            stage_ctrl.load_pc     = imem_resp;
            stage_ctrl.load_if_id  = 1'b1;
            stage_ctrl.load_id_ex  = 1'b1;
            stage_ctrl.load_ex_mem = 1'b1;
            stage_ctrl.load_mem_wb = 1'b1;
            stage_ctrl.flush_if_id = 1'b1;
            stage_ctrl.flush_id_ex = 1'b1;
        end else if (id_stall) begin
            // fetch and decode hold, bubble into execute
            stage_ctrl.load_id_ex  = 1'b1;
            stage_ctrl.load_ex_mem = 1'b1;
            stage_ctrl.load_mem_wb = 1'b1;
            stage_ctrl.flush_id_ex = 1'b1;
        end else begin
            stage_ctrl.load_pc     = imem_resp;
            stage_ctrl.load_if_id  = 1'b1;
            stage_ctrl.load_id_ex  = 1'b1;
            stage_ctrl.load_ex_mem = 1'b1;
            stage_ctrl.load_mem_wb = 1'b1;
            // slow fetch sends a bubble down
            stage_ctrl.flush_if_id = !imem_resp;
        end
    end

endmodule : hazard_unit

/* pipeline_pkg.sv */
package pipeline_pkg;

    import rv32i_types::*;

    // used in execute
    typedef struct packed {
        alu_op_t aluop;
        logic    imm_sel;
        logic    branch;
        logic    branch_ne;
    } ctrlex_reg_t;

    // used in memory
    typedef struct packed {
        logic dmem_read;
        logic dmem_write;
    } ctrlmem_reg_t;

    // used in writeback, the indices also feed the hazard compare
    typedef struct packed {
        logic   regwrite;
        logic   mem_to_reg;
        logic   valid;
        reg_idx rs1;
        reg_idx rs2;
        reg_idx rd;
    } ctrlwb_reg_t;

    // one source operand of the decode stage
    typedef struct packed {
        reg_idx idx;
        logic   used;
    } dep_t;

    typedef struct packed {
        logic load_pc;
        logic load_if_id;
        logic load_id_ex;
        logic load_ex_mem;
        logic load_mem_wb;
        logic flush_if_id;
        logic flush_id_ex;
    } stage_ctrl_t;

endpackage : pipeline_pkg

/* run_sim.sh */
#!/bin/sh
# build and run the tb_cpu simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_cpu \
    -o tb_cpu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "compile failed"
    exit 1
fi

./obj_dir/tb_cpu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
exit 0

/* rv32i_types.sv */
package rv32i_types;

    // data and address word
    typedef logic [31:0] rv32i_word;

    // register file index
    typedef logic [4:0] reg_idx;

    // instruction function fields
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_reg   = 7'b0110011,
        op_imm   = 7'b0010011,
        op_lui   = 7'b0110111,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_br    = 7'b1100011
    } rv32i_opcode;

    // alu functions, add is the zero encoding
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_op_t;

endpackage : rv32i_types

/* tb_cpu.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module tb_cpu
    import rv32i_types::*;
();

    localparam int NUM_STORES = 15;
    localparam int TIMEOUT    = 2000;

    typedef struct packed {
        logic [2:0] test;
        rv32i_word  addr;
        rv32i_word  data;
    } store_t;

    logic       clk;
    logic       reset;
    logic       imem_read;
    rv32i_word  imem_address;
    logic       imem_resp;
    rv32i_word  imem_rdata;
    logic       dmem_read;
    logic       dmem_write;
    logic [3:0] dmem_wmask;
    rv32i_word  dmem_address;
    rv32i_word  dmem_wdata;
    logic       dmem_resp;
    rv32i_word  dmem_rdata;

    store_t     expected [NUM_STORES];
    int         test_err [6];
    int         store_count;
    logic       timed_out;
    logic       ipend, dpend, dpend_wr;
    rv32i_word  ipend_addr, dpend_addr, dpend_data;
    int         i;
    int         total;

    cpu dut_i (
        .clk          (clk),
        .reset        (reset),
        .imem_read    (imem_read),
        .imem_address (imem_address),
        .imem_resp    (imem_resp),
        .imem_rdata   (imem_rdata),
        .dmem_read    (dmem_read),
        .dmem_write   (dmem_write),
        .dmem_wmask   (dmem_wmask),
        .dmem_address (dmem_address),
        .dmem_wdata   (dmem_wdata),
        .dmem_resp    (dmem_resp),
        .dmem_rdata   (dmem_rdata)
    );

    tb_mem mem_i (
        .clk          (clk),
        .imem_read    (imem_read),
        .imem_address (imem_address),
        .imem_resp    (imem_resp),
        .imem_rdata   (imem_rdata),
        .dmem_read    (dmem_read),
        .dmem_write   (dmem_write),
        .dmem_address (dmem_address),
        .dmem_wdata   (dmem_wdata),
        .dmem_resp    (dmem_resp),
        .dmem_rdata   (dmem_rdata)
    );

    always #5 clk = ~clk;

    task automatic check_value(string name, rv32i_word got, rv32i_word exp, int test);
        assert (got === exp) else begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, got);
            test_err[test]++;
        end
    endtask

    task automatic check_idle(string phase);
        check_value({"imem_read ", phase}, 32'(imem_read), 32'd0, 1);
        check_value({"dmem_read ", phase}, 32'(dmem_read), 32'd0, 1);
        check_value({"dmem_write ", phase}, 32'(dmem_write), 32'd0, 1);
    endtask

    // architectural results of the program in tb_mem
    task automatic load_expected();
        expected[0]  = '{3'd3, 32'h100, 32'h0000_0002};
        expected[1]  = '{3'd2, 32'h104, 32'h0000_0008};
        expected[2]  = '{3'd2, 32'h108, 32'h0000_0005};
        expected[3]  = '{3'd2, 32'h10c, 32'hffff_fffd};
        expected[4]  = '{3'd2, 32'h110, 32'hffff_fff8};
        expected[5]  = '{3'd2, 32'h114, 32'h0000_0001};
        expected[6]  = '{3'd2, 32'h118, 32'h0000_00f0};
        expected[7]  = '{3'd2, 32'h11c, 32'h0000_0105};
        expected[8]  = '{3'd2, 32'h120, 32'hffff_fffa};
        expected[9]  = '{3'd2, 32'h124, 32'h0000_0001};
        expected[10] = '{3'd2, 32'h128, 32'h1234_5000};
        expected[11] = '{3'd3, 32'h12c, 32'h0000_0009};
        expected[12] = '{3'd4, 32'h138, 32'h0000_0002};
        expected[13] = '{3'd4, 32'h13c, 32'h0000_0008};
        expected[14] = '{3'd4, 32'h144, 32'h0000_0005};
    endtask

    task automatic wait_for_stores(int n);
        int cycles;
        cycles = 0;
        while (!timed_out && store_count < n && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!timed_out && store_count < n) begin
            $display("timeout after %0d cycles with %0d of %0d stores seen",
                     TIMEOUT, store_count, n);
            timed_out = 1'b1;
        end
    endtask

    task automatic report_test(int n, string name);
        $display("test %0d %s: %s (%0d errors)", n, name,
                 (test_err[n] == 0 && !timed_out) ? "ok" : "failed", test_err[n]);
    endtask

    // store completions against the reference list
    always @(negedge clk) begin
        if (!reset && dmem_write && dmem_resp) begin
            assert (store_count < NUM_STORES) else begin
                $display("store to %h with %h after the last expected store",
                         dmem_address, dmem_wdata);
                test_err[4]++;
            end
            if (store_count < NUM_STORES) begin
                check_value("dmem_address", dmem_address,
                            expected[store_count].addr, int'(expected[store_count].test));
                check_value("dmem_wdata", dmem_wdata,
                            expected[store_count].data, int'(expected[store_count].test));
                check_value("dmem_wmask", 32'(dmem_wmask), 32'h0000_000f, 5);
            end
            store_count++;
        end
    end

    // a request without resp must come back unchanged
    always @(negedge clk) begin
        if (reset) begin
            ipend <= 1'b0;
            dpend <= 1'b0;
        end else begin
            if (ipend) begin
                check_value("imem_read", 32'(imem_read), 32'd1, 5);
                check_value("imem_address", imem_address, ipend_addr, 5);
            end
            if (dpend) begin
                check_value("dmem_write", 32'(dmem_write), 32'(dpend_wr), 5);
                check_value("dmem_read", 32'(dmem_read), 32'(!dpend_wr), 5);
                check_value("dmem_address", dmem_address, dpend_addr, 5);
                if (dpend_wr)
                    check_value("dmem_wdata", dmem_wdata, dpend_data, 5);
            end
            ipend      <= imem_read && !imem_resp;
            ipend_addr <= imem_address;
            dpend      <= (dmem_read || dmem_write) && !dmem_resp;
            dpend_wr   <= dmem_write;
            dpend_addr <= dmem_address;
            dpend_data <= dmem_wdata;
        end
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        store_count = 0;
        timed_out   = 1'b0;
        total       = 0;
        for (i = 0; i < 6; i++)
            test_err[i] = 0;
        load_expected();

        for (i = 0; i < 10; i++) begin
            @(negedge clk);
            check_idle("in reset");
        end
        @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        check_idle("after reset");
        @(negedge clk);
        check_value("imem_read", 32'(imem_read), 32'd1, 1);
        check_value("imem_address", imem_address, `CPU_RESET_PC, 1);
        report_test(1, "reset and first fetch");

        wait_for_stores(11);
        report_test(2, "alu, immediate and lui stores");
        wait_for_stores(12);
        report_test(3, "dependency and load-use stalls");
        wait_for_stores(NUM_STORES);
        // give a flushed store time to show up
        repeat (50) @(posedge clk);
        report_test(4, "branch control flow");
        report_test(5, "request hold under random delays");

        for (i = 1; i < 6; i++)
            total += test_err[i];
        $display("tests run: 5, stores seen: %0d of %0d, errors: %0d, timeout: %0d",
                 store_count, NUM_STORES, total, timed_out);
        if (total == 0 && !timed_out && store_count == NUM_STORES) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : tb_cpu

/* tb_mem.sv */
`timescale 1ns/1ps

module tb_mem
    import rv32i_types::*;
(
    input  logic      clk,
    input  logic      imem_read,
    input  rv32i_word imem_address,
    output logic      imem_resp,
    output rv32i_word imem_rdata,
    input  logic      dmem_read,
    input  logic      dmem_write,
    input  rv32i_word dmem_address,
    input  rv32i_word dmem_wdata,
    output logic      dmem_resp,
    output rv32i_word dmem_rdata
);

    rv32i_word imem [256];
    rv32i_word dmem [256];
    int        seed;
    int        iwait;
    int        dwait;
    int        i;

    function automatic rv32i_word encode_r(logic [6:0] f7, reg_idx rs2, reg_idx rs1,
                                           logic [2:0] f3, reg_idx rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic rv32i_word encode_i(logic [11:0] imm, reg_idx rs1, logic [2:0] f3,
                                           reg_idx rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv32i_word encode_s(logic [11:0] imm, reg_idx rs2, reg_idx rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic rv32i_word encode_b(logic [12:0] imm, reg_idx rs2, reg_idx rs1,
                                           logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    // response delay of 0 to 3 cycles
    function int next_delay();
        return $unsigned($random(seed)) % 4;
    endfunction

    initial begin
        seed       = 32'hc44;
        imem_resp  = 1'b0;
        dmem_resp  = 1'b0;
        imem_rdata = '0;
        dmem_rdata = '0;
        for (i = 0; i < 256; i++) begin
            imem[i] = '0;
            dmem[i] = 32'h5a5a_0000 | (32'(i) << 2);
        end
        // alu and back-to-back dependencies
        imem[0]  = encode_i(12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011);
        imem[1]  = encode_i(12'hffd, 5'd0, 3'b000, 5'd2, 7'b0010011);
        imem[2]  = encode_r(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3);
        imem[3]  = encode_s(12'h100, 5'd3, 5'd0);
        imem[4]  = encode_r(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd4);
        imem[5]  = encode_s(12'h104, 5'd4, 5'd0);
        imem[6]  = encode_r(7'b0000000, 5'd2, 5'd1, 3'b111, 5'd5);
        imem[7]  = encode_r(7'b0000000, 5'd2, 5'd1, 3'b110, 5'd6);
        imem[8]  = encode_r(7'b0000000, 5'd2, 5'd1, 3'b100, 5'd7);
        imem[9]  = encode_r(7'b0000000, 5'd1, 5'd2, 3'b010, 5'd8);
        imem[10] = encode_s(12'h108, 5'd5, 5'd0);
        imem[11] = encode_s(12'h10c, 5'd6, 5'd0);
        imem[12] = encode_s(12'h110, 5'd7, 5'd0);
        imem[13] = encode_s(12'h114, 5'd8, 5'd0);
        // immediates and lui
        imem[14] = encode_i(12'h0f0, 5'd2, 3'b111, 5'd9, 7'b0010011);
        imem[15] = encode_i(12'h100, 5'd1, 3'b110, 5'd10, 7'b0010011);
        imem[16] = encode_i(12'hfff, 5'd1, 3'b100, 5'd11, 7'b0010011);
        imem[17] = encode_i(12'd6, 5'd1, 3'b010, 5'd12, 7'b0010011);
        imem[18] = {20'h12345, 5'd13, 7'b0110111};
        imem[19] = encode_s(12'h118, 5'd9, 5'd0);
        imem[20] = encode_s(12'h11c, 5'd10, 5'd0);
        imem[21] = encode_s(12'h120, 5'd11, 5'd0);
        imem[22] = encode_s(12'h124, 5'd12, 5'd0);
        imem[23] = encode_s(12'h128, 5'd13, 5'd0);
        // load-use
        imem[24] = encode_i(12'h100, 5'd0, 3'b010, 5'd14, 7'b0000011);
        imem[25] = encode_i(12'd7, 5'd14, 3'b000, 5'd15, 7'b0010011);
        imem[26] = encode_s(12'h12c, 5'd15, 5'd0);
        // branches, stores at 28, 29 and 35 are skipped
        imem[27] = encode_b(13'd12, 5'd1, 5'd1, 3'b000);
        imem[28] = encode_s(12'h130, 5'd1, 5'd0);
        imem[29] = encode_s(12'h134, 5'd2, 5'd0);
        imem[30] = encode_b(13'd8, 5'd1, 5'd1, 3'b001);
        imem[31] = encode_s(12'h138, 5'd3, 5'd0);
        imem[32] = encode_b(13'd8, 5'd2, 5'd1, 3'b000);
        imem[33] = encode_s(12'h13c, 5'd4, 5'd0);
        imem[34] = encode_b(13'd8, 5'd2, 5'd1, 3'b001);
        imem[35] = encode_s(12'h140, 5'd5, 5'd0);
        imem[36] = encode_s(12'h144, 5'd1, 5'd0);
        // spin in place
        imem[37] = encode_b(13'd0, 5'd0, 5'd0, 3'b000);
        iwait = next_delay();
        dwait = next_delay();
    end

    always @(posedge clk) begin
        #1;
        imem_resp = 1'b0;
        dmem_resp = 1'b0;
        if (imem_read) begin
            if (iwait == 0) begin
                imem_resp  = 1'b1;
                imem_rdata = imem[imem_address[9:2]];
                iwait      = next_delay();
            end else begin
                iwait = iwait - 1;
            end
        end
        if (dmem_read || dmem_write) begin
            if (dwait == 0) begin
                dmem_resp = 1'b1;
                if (dmem_write)
                    dmem[dmem_address[9:2]] = dmem_wdata;
                else
                    dmem_rdata = dmem[dmem_address[9:2]];
                dwait = next_delay();
            end else begin
                dwait = dwait - 1;
            end
        end
    end

endmodule : tb_mem

/* verilog.f */
+incdir+.
rv32i_types.sv
pipeline_pkg.sv
ctrl_word.sv
ctrl_pipe.sv
datapath.sv
hazard_unit.sv
cpu.sv
tb_mem.sv
tb_cpu.sv
